// File: bus_monitor.sv
// SCL/SDA synchronizer and bus condition detector, one instance per standby engine
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_o,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o
);

  logic [`STANDBY_SYNC_STAGES-1:0] scl_sync;
  logic [`STANDBY_SYNC_STAGES-1:0] sda_sync;
  logic                            scl_s;
  logic                            sda_s;
  logic                            scl_q;
  logic                            sda_q;
  logic                            start_det;
  logic                            stop_det;
  logic                            xfer_open;

  assign scl_s = scl_sync[`STANDBY_SYNC_STAGES-1];
  assign sda_s = sda_sync[`STANDBY_SYNC_STAGES-1];

  // SDA edges while SCL stays high
  assign start_det = scl_s & scl_q & sda_q & ~sda_s;
  assign stop_det  = scl_s & scl_q & ~sda_q & sda_s;

  // Lines idle high, so the chain resets to ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[`STANDBY_SYNC_STAGES-2:0], scl_i};
      sda_sync <= {sda_sync[`STANDBY_SYNC_STAGES-2:0], sda_i};
      scl_q    <= scl_s;
      sda_q    <= sda_s;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      start_o    <= 1'b0;
      rstart_o   <= 1'b0;
      stop_o     <= 1'b0;
      xfer_open  <= 1'b0;
    end else begin
      scl_rise_o <= scl_s & ~scl_q;
      scl_fall_o <= ~scl_s & scl_q;
      start_o    <= start_det & ~xfer_open;
      rstart_o   <= start_det & xfer_open;
      stop_o     <= stop_det;
      if (start_det) begin
        xfer_open <= 1'b1;
      end else if (stop_det) begin
        xfer_open <= 1'b0;
      end
    end
  end

  // Delayed copy lines up with the registered strobes
  assign sda_o = sda_q;

endmodule

`default_nettype wire

// File: controller_ifs.sv
// RX queue write and bus event interfaces between the standby engines and the top level
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

// Queue writes, all strobes single cycle, no back-pressure
interface tti_rx_if;
  logic                       desc_wvalid;
  controller_pkg::rx_desc_t   desc_wdata;
  logic                       data_wvalid;
  logic [`STANDBY_DATA_W-1:0] data_wdata;
  logic                       data_wflush;

  modport engine(
    output desc_wvalid, desc_wdata, data_wvalid, data_wdata, data_wflush
  );

  modport sink(
    input desc_wvalid, desc_wdata, data_wvalid, data_wdata, data_wflush
  );
endinterface

// Bus conditions and the received address byte, RnW in bit 0
interface bus_evt_if;
  logic       start;
  logic       rstart;
  logic       stop;
  logic [7:0] addr;
  logic       addr_valid;

  modport monitor(output start, rstart, stop, addr, addr_valid);

  modport sink(input start, rstart, stop, addr, addr_valid);
endinterface

`default_nettype wire

// File: controller_pkg.sv
// Types shared by the standby engines and the top level, reached by scoped name
`include "standby_macros.svh"

`default_nettype none

package controller_pkg;

  // Bus protocol the target answers in
  typedef enum logic {
    MODE_I2C = 1'b0,
    MODE_I3C = 1'b1
  } bus_mode_e;

  // One descriptor per received write segment
  typedef struct packed {
    // Always zero
    logic [`STANDBY_DESC_W-27:0] reserved;
    logic                        parity_err;
    bus_mode_e                   mode;
    logic [6:0]                  addr;
    // Good bytes only
    logic [15:0]                 byte_count;
  } rx_desc_t;

endpackage

`default_nettype wire

// File: controller_standby.sv
// Standby target top level: picks I2C or I3C mode and muxes both engines onto the queue ports
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

module controller_standby (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       ctrl_scl_i,
  input  logic                       ctrl_sda_i,
  input  logic                       i3c_standby_en_i,
  input  logic [6:0]                 target_sta_addr_i,
  input  logic                       target_sta_addr_valid_i,
  input  logic [6:0]                 target_dyn_addr_i,
  input  logic                       target_dyn_addr_valid_i,
  output logic                       ctrl_sda_o,
  output logic                       rx_desc_queue_wvalid_o,
  output controller_pkg::rx_desc_t   rx_desc_queue_wdata_o,
  output logic                       rx_queue_wvalid_o,
  output logic [`STANDBY_DATA_W-1:0] rx_queue_wdata_o,
  output logic                       rx_queue_wflush_o,
  output logic                       bus_start_o,
  output logic                       bus_rstart_o,
  output logic                       bus_stop_o,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o
);

  controller_pkg::bus_mode_e mode;
  logic                      sel_i3c;
  logic                      i2c_sda;
  logic                      i3c_sda;

  tti_rx_if  i2c_rx ();
  tti_rx_if  i3c_rx ();
  bus_evt_if i2c_evt ();
  bus_evt_if i3c_evt ();

  assign mode    = i3c_standby_en_i ? controller_pkg::MODE_I3C : controller_pkg::MODE_I2C;
  assign sel_i3c = (mode == controller_pkg::MODE_I3C);

  controller_standby_i2c u_i2c (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .en_i                   (!sel_i3c),
    .scl_i                  (ctrl_scl_i),
    .sda_i                  (ctrl_sda_i),
    .target_sta_addr_i      (target_sta_addr_i),
    .target_sta_addr_valid_i(target_sta_addr_valid_i),
    .sda_o                  (i2c_sda),
    .rx                     (i2c_rx.engine),
    .evt                    (i2c_evt.monitor)
  );

  controller_standby_i3c u_i3c (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .en_i                   (sel_i3c),
    .scl_i                  (ctrl_scl_i),
    .sda_i                  (ctrl_sda_i),
    .target_sta_addr_i      (target_sta_addr_i),
    .target_sta_addr_valid_i(target_sta_addr_valid_i),
    .target_dyn_addr_i      (target_dyn_addr_i),
    .target_dyn_addr_valid_i(target_dyn_addr_valid_i),
    .sda_o                  (i3c_sda),
    .rx                     (i3c_rx.engine),
    .evt                    (i3c_evt.monitor)
  );

  // Output mux, no added latency
  always_comb begin
    ctrl_sda_o             = sel_i3c ? i3c_sda : i2c_sda;
    rx_desc_queue_wvalid_o = sel_i3c ? i3c_rx.desc_wvalid : i2c_rx.desc_wvalid;
    rx_desc_queue_wdata_o  = sel_i3c ? i3c_rx.desc_wdata : i2c_rx.desc_wdata;
    rx_queue_wvalid_o      = sel_i3c ? i3c_rx.data_wvalid : i2c_rx.data_wvalid;
    rx_queue_wdata_o       = sel_i3c ? i3c_rx.data_wdata : i2c_rx.data_wdata;
    rx_queue_wflush_o      = sel_i3c ? i3c_rx.data_wflush : i2c_rx.data_wflush;
    bus_start_o            = sel_i3c ? i3c_evt.start : i2c_evt.start;
    bus_rstart_o           = sel_i3c ? i3c_evt.rstart : i2c_evt.rstart;
    bus_stop_o             = sel_i3c ? i3c_evt.stop : i2c_evt.stop;
    bus_addr_o             = sel_i3c ? i3c_evt.addr : i2c_evt.addr;
    bus_addr_valid_o       = sel_i3c ? i3c_evt.addr_valid : i2c_evt.addr_valid;
  end

endmodule

`default_nettype wire

// File: controller_standby_cases.txt
# mode sta_valid sta_addr dyn_valid dyn_addr addr_byte count data corrupt_index end
# data is hex bytes joined by ':' or the word random, corrupt_index -1 means none
i2c 1 50 0 00 a0 3 11:22:33 -1 stop
i2c 1 50 0 00 a4 2 de:ad -1 stop
i2c 1 50 0 00 a1 1 5a -1 stop
i2c 1 50 0 00 a0 4 random -1 stop
i3c 1 50 1 31 62 3 01:80:ff -1 stop
i3c 1 50 1 31 a0 2 12:34 -1 stop
i3c 1 50 0 31 a0 2 12:34 -1 stop
i3c 1 50 1 31 62 4 aa:bb:cc:dd 2 stop
i3c 1 50 1 31 62 3 random 0 stop
i2c 1 50 0 00 a0 2 01:02 -1 rstart
i2c 1 50 0 00 a0 1 03 -1 stop
i3c 1 50 1 31 62 2 random -1 rstart
i3c 1 50 1 31 fc 1 77 -1 stop
i3c 0 50 0 31 fc 2 9c:01 -1 stop
i2c 1 50 0 00 fc 1 9c -1 stop
i3c 1 50 1 31 62 3 random 1 rstart
i3c 1 50 1 31 62 2 random -1 stop

// File: controller_standby_i2c.sv
// I2C standby target engine: static address match, ACK and RX byte and descriptor writes
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

module controller_standby_i2c (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       en_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic [6:0] target_sta_addr_i,
  input  logic       target_sta_addr_valid_i,
  output logic       sda_o,
  tti_rx_if.engine   rx,
  bus_evt_if.monitor evt
);

  logic                       scl_rise;
  logic                       scl_fall;
  logic                       sda_s;
  logic                       start;
  logic                       rstart;
  logic                       stop;
  logic                       seg_begin;
  logic                       seg_end;
  logic [3:0]                 bit_cnt;
  logic [`STANDBY_DATA_W-1:0] shift_q;
  logic [`STANDBY_DATA_W-1:0] rx_byte;
  logic                       addr_phase;
  logic                       matched;
  logic                       ack_drive;
  logic [15:0]                byte_cnt;

  bus_monitor u_bus_monitor (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .sda_o     (sda_s),
    .start_o   (start),
    .rstart_o  (rstart),
    .stop_o    (stop)
  );

  assign seg_begin = start | rstart;
  assign seg_end   = stop | rstart;
  assign rx_byte   = {shift_q[`STANDBY_DATA_W-2:0], sda_s};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bit_cnt        <= '0;
      addr_phase     <= 1'b0;
      matched        <= 1'b0;
      ack_drive      <= 1'b0;
      byte_cnt       <= '0;
      evt.addr_valid <= 1'b0;
      rx.data_wvalid <= 1'b0;
      rx.desc_wvalid <= 1'b0;
    end else begin
      evt.addr_valid <= 1'b0;
      rx.data_wvalid <= 1'b0;
      rx.desc_wvalid <= seg_end && matched && (byte_cnt != '0);
      if (seg_begin || stop) begin
        bit_cnt    <= '0;
        addr_phase <= seg_begin;
        matched    <= 1'b0;
        ack_drive  <= 1'b0;
        byte_cnt   <= '0;
      end else if (scl_rise) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd7) begin
          if (addr_phase) begin
            evt.addr_valid <= en_i;
            // Writes to our static address only
            matched <= en_i && target_sta_addr_valid_i && !rx_byte[0] &&
                       (rx_byte[7:1] == target_sta_addr_i);
          end else if (matched) begin
            rx.data_wvalid <= 1'b1;
            byte_cnt       <= byte_cnt + 16'd1;
          end
        end
      end else if (scl_fall) begin
        // Hold SDA low through the ninth clock
        if (bit_cnt == 4'd8) begin
          ack_drive <= matched;
        end else if (bit_cnt == 4'd9) begin
          ack_drive  <= 1'b0;
          bit_cnt    <= '0;
          addr_phase <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && bit_cnt < 4'd8) begin
      shift_q <= rx_byte;
    end
    if (scl_rise && bit_cnt == 4'd7) begin
      if (addr_phase) begin
        evt.addr <= rx_byte;
      end
      rx.data_wdata <= rx_byte;
    end
    if (seg_end) begin
      rx.desc_wdata <= '{reserved: '0, parity_err: 1'b0, mode: controller_pkg::MODE_I2C,
                         addr: evt.addr[7:1], byte_count: byte_cnt};
    end
  end

  // No parity in I2C, nothing to flush
  assign rx.data_wflush = 1'b0;

  assign evt.start  = en_i & start;
  assign evt.rstart = en_i & rstart;
  assign evt.stop   = en_i & stop;

  assign sda_o = ~ack_drive;

endmodule

`default_nettype wire

// File: controller_standby_i3c.sv
// I3C SDR standby target engine: address match, T-bit parity check and RX queue writes
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

module controller_standby_i3c (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       en_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic [6:0] target_sta_addr_i,
  input  logic       target_sta_addr_valid_i,
  input  logic [6:0] target_dyn_addr_i,
  input  logic       target_dyn_addr_valid_i,
  output logic       sda_o,
  tti_rx_if.engine   rx,
  bus_evt_if.monitor evt
);

  logic                       scl_rise;
  logic                       scl_fall;
  logic                       sda_s;
  logic                       start;
  logic                       rstart;
  logic                       stop;
  logic                       seg_begin;
  logic                       seg_end;
  logic [3:0]                 bit_cnt;
  logic [`STANDBY_DATA_W-1:0] shift_q;
  logic [`STANDBY_DATA_W-1:0] rx_byte;
  logic                       own_hit;
  logic                       addr_phase;
  logic                       matched;
  logic                       ack_drive;
  logic                       parity_err;
  logic [15:0]                byte_cnt;

  bus_monitor u_bus_monitor (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .sda_o     (sda_s),
    .start_o   (start),
    .rstart_o  (rstart),
    .stop_o    (stop)
  );

  assign seg_begin = start | rstart;
  assign seg_end   = stop | rstart;
  assign rx_byte   = {shift_q[`STANDBY_DATA_W-2:0], sda_s};

  // Dynamic address wins once assigned
  assign own_hit = target_dyn_addr_valid_i ? (rx_byte[7:1] == target_dyn_addr_i) :
                   (target_sta_addr_valid_i && (rx_byte[7:1] == target_sta_addr_i));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bit_cnt         <= '0;
      addr_phase      <= 1'b0;
      matched         <= 1'b0;
      ack_drive       <= 1'b0;
      parity_err      <= 1'b0;
      byte_cnt        <= '0;
      evt.addr_valid  <= 1'b0;
      rx.data_wvalid  <= 1'b0;
      rx.data_wflush  <= 1'b0;
      rx.desc_wvalid  <= 1'b0;
    end else begin
      evt.addr_valid <= 1'b0;
      rx.data_wvalid <= 1'b0;
      rx.data_wflush <= 1'b0;
      rx.desc_wvalid <= seg_end && matched && ((byte_cnt != '0) || parity_err);
      if (seg_begin || stop) begin
        bit_cnt    <= '0;
        addr_phase <= seg_begin;
        matched    <= 1'b0;
        ack_drive  <= 1'b0;
        parity_err <= 1'b0;
        byte_cnt   <= '0;
      end else if (scl_rise) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (addr_phase && bit_cnt == 4'd7) begin
          evt.addr_valid <= en_i;
          matched <= en_i && !rx_byte[0] &&
                     (own_hit || rx_byte[7:1] == `STANDBY_BCAST_ADDR);
        end else if (!addr_phase && bit_cnt == 4'd8 && matched && !parity_err) begin
          // T-bit gives odd parity over the byte
          if (sda_s == ~^shift_q) begin
            rx.data_wvalid <= 1'b1;
            byte_cnt       <= byte_cnt + 16'd1;
          end else begin
            rx.data_wflush <= 1'b1;
            parity_err     <= 1'b1;
          end
        end
      end else if (scl_fall) begin
        // Only the address is ACKed, data words end in a T-bit
        if (bit_cnt == 4'd8) begin
          ack_drive <= addr_phase && matched;
        end else if (bit_cnt == 4'd9) begin
          ack_drive  <= 1'b0;
          bit_cnt    <= '0;
          addr_phase <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && bit_cnt < 4'd8) begin
      shift_q <= rx_byte;
    end
    if (scl_rise && addr_phase && bit_cnt == 4'd7) begin
      evt.addr <= rx_byte;
    end
    if (scl_rise && bit_cnt == 4'd8) begin
      rx.data_wdata <= shift_q;
    end
    if (seg_end) begin
      rx.desc_wdata <= '{reserved: '0, parity_err: parity_err,
                         mode: controller_pkg::MODE_I3C,
                         addr: evt.addr[7:1], byte_count: byte_cnt};
    end
  end

  assign evt.start  = en_i & start;
  assign evt.rstart = en_i & rstart;
  assign evt.stop   = en_i & stop;

  // Open drain, 1 releases the line
  assign sda_o = ~ack_drive;

endmodule

`default_nettype wire

// File: controller_standby_props.sv
// Concurrent checks on the standby top level outputs, attached to controller_standby with bind
`timescale 1ns/1ns

`default_nettype none

module controller_standby_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic start_i,
  input logic rstart_i,
  input logic stop_i,
  input logic addr_valid_i,
  input logic data_wvalid_i,
  input logic data_wflush_i,
  input logic desc_wvalid_i
);

  logic in_reset_q;

  // Strobes are registered, so look one edge into reset
  always_ff @(posedge clk_i) begin
    in_reset_q <= !rst_n_i;
  end

  a_start_stop : assert property (@(posedge clk_i) !(start_i && stop_i))
    else $error("start and stop strobed in the same cycle");

  a_data_desc : assert property (@(posedge clk_i) !(data_wvalid_i && desc_wvalid_i))
    else $error("data and descriptor writes in the same cycle");

  a_reset_quiet : assert property (@(posedge clk_i) (!rst_n_i && in_reset_q) |->
    !(start_i || rstart_i || stop_i || addr_valid_i || data_wvalid_i ||
      data_wflush_i || desc_wvalid_i))
    else $error("strobe high during reset");

endmodule

bind controller_standby controller_standby_props u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .start_i      (bus_start_o),
  .rstart_i     (bus_rstart_o),
  .stop_i       (bus_stop_o),
  .addr_valid_i (bus_addr_valid_o),
  .data_wvalid_i(rx_queue_wvalid_o),
  .data_wflush_i(rx_queue_wflush_o),
  .desc_wvalid_i(rx_desc_queue_wvalid_o)
);

`default_nettype wire

// File: controller_standby_tb.sv
// Testbench for controller_standby, replays bus segments from controller_standby_cases.txt
`timescale 1ns/1ns
`include "standby_macros.svh"

`default_nettype none

module controller_standby_tb;

  localparam int MAX_CASES = 64;

  logic clk = 1'b0;
  logic rst_n_i, scl_drv, sda_drv, i3c_en, sta_valid, dyn_valid;
  logic [6:0] sta_addr, dyn_addr;
  logic sda_line, ctrl_sda_o;
  logic rx_desc_queue_wvalid_o, rx_queue_wvalid_o, rx_queue_wflush_o;
  controller_pkg::rx_desc_t rx_desc_queue_wdata_o;
  logic [`STANDBY_DATA_W-1:0] rx_queue_wdata_o;
  logic bus_start_o, bus_rstart_o, bus_stop_o, bus_addr_valid_o;
  logic [7:0] bus_addr_o;

  // Case table
  int n_cases, total_bits;
  bit loaded;
  bit c_i3c[MAX_CASES], c_sv[MAX_CASES], c_dv[MAX_CASES], c_rstart[MAX_CASES];
  logic [6:0] c_sta[MAX_CASES], c_dyn[MAX_CASES];
  logic [7:0] c_addr[MAX_CASES];
  int c_cnt[MAX_CASES], c_corrupt[MAX_CASES];
  string c_data[MAX_CASES];

  // Expected and observed results of the current window
  logic [7:0] exp_bytes[$], got_bytes[$], exp_addrs[$], got_addrs[$];
  controller_pkg::rx_desc_t exp_descs[$], got_descs[$];
  int exp_start, exp_rstart, exp_stop, exp_flush;
  int got_start, got_rstart, got_stop, got_flush;
  bit bus_open;

  // Open drain line
  assign sda_line = sda_drv & ctrl_sda_o;

  controller_standby u_dut (
    .clk_i                  (clk),
    .rst_n_i                (rst_n_i),
    .ctrl_scl_i             (scl_drv),
    .ctrl_sda_i             (sda_line),
    .i3c_standby_en_i       (i3c_en),
    .target_sta_addr_i      (sta_addr),
    .target_sta_addr_valid_i(sta_valid),
    .target_dyn_addr_i      (dyn_addr),
    .target_dyn_addr_valid_i(dyn_valid),
    .ctrl_sda_o             (ctrl_sda_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_queue_wflush_o      (rx_queue_wflush_o),
    .bus_start_o            (bus_start_o),
    .bus_rstart_o           (bus_rstart_o),
    .bus_stop_o             (bus_stop_o),
    .bus_addr_o             (bus_addr_o),
    .bus_addr_valid_o       (bus_addr_valid_o)
  );

  initial begin
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_byte(string name, logic [`STANDBY_DATA_W-1:0] got,
                            logic [`STANDBY_DATA_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp));
    end
  endtask

  task automatic check_desc(string name, controller_pkg::rx_desc_t got,
                            controller_pkg::rx_desc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Observed strobes, sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (rx_queue_wvalid_o) got_bytes.push_back(rx_queue_wdata_o);
      if (rx_desc_queue_wvalid_o) got_descs.push_back(rx_desc_queue_wdata_o);
      if (bus_addr_valid_o) got_addrs.push_back(bus_addr_o);
      if (rx_queue_wflush_o) got_flush++;
      if (bus_start_o) got_start++;
      if (bus_rstart_o) got_rstart++;
      if (bus_stop_o) got_stop++;
    end
  end

  task automatic wait_clk(int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_bit(logic b);
    sda_drv <= b;
    wait_clk(2);
    scl_drv <= 1'b1;
    wait_clk(3);
    scl_drv <= 1'b0;
    wait_clk(3);
  endtask

  task automatic drive_byte(logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      drive_bit(b[i]);
    end
  endtask

  // Release SDA for the ninth clock and sample the target's drive
  task automatic ack_slot(output logic seen);
    sda_drv <= 1'b1;
    wait_clk(2);
    scl_drv <= 1'b1;
    wait_clk(2);
    @(negedge clk);
    seen = ctrl_sda_o;
    wait_clk(1);
    scl_drv <= 1'b0;
    wait_clk(3);
  endtask

  task automatic drive_start();
    sda_drv <= 1'b0;
    wait_clk(4);
    scl_drv <= 1'b0;
    wait_clk(4);
  endtask

  task automatic drive_rstart();
    sda_drv <= 1'b1;
    wait_clk(3);
    scl_drv <= 1'b1;
    wait_clk(3);
    sda_drv <= 1'b0;
    wait_clk(3);
    scl_drv <= 1'b0;
    wait_clk(3);
  endtask

  task automatic drive_stop();
    sda_drv <= 1'b0;
    wait_clk(2);
    scl_drv <= 1'b1;
    wait_clk(3);
    sda_drv <= 1'b1;
    wait_clk(6);
  endtask

  task automatic load_cases();
    int fd, items, sv, sta, dv, dyn, addr, cnt, corrupt;
    string line, mode_s, data_s, end_s;
    fd = $fopen("controller_standby_cases.txt", "r");
    if (fd == 0) abort_run("cannot open controller_standby_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      items = $fgets(line, fd);
      if (line.len() < 4 || line.getc(0) == "#") continue;
      items = $sscanf(line, "%s %d %h %d %h %h %d %s %d %s", mode_s, sv, sta, dv, dyn,
                      addr, cnt, data_s, corrupt, end_s);
      if (items != 10 || n_cases >= MAX_CASES) abort_run({"bad cases line: ", line});
      c_i3c[n_cases]     = (mode_s == "i3c");
      c_sv[n_cases]      = (sv != 0);
      c_sta[n_cases]     = 7'(sta);
      c_dv[n_cases]      = (dv != 0);
      c_dyn[n_cases]     = 7'(dyn);
      c_addr[n_cases]    = 8'(addr);
      c_cnt[n_cases]     = cnt;
      c_data[n_cases]    = data_s;
      c_corrupt[n_cases] = corrupt;
      c_rstart[n_cases]  = (end_s == "rstart");
      total_bits += 11 + 9 * cnt;
      n_cases++;
    end
    $fclose(fd);
  endtask

  task automatic verify_window();
    check_count("bus_start_o strobes", got_start, exp_start);
    check_count("bus_rstart_o strobes", got_rstart, exp_rstart);
    check_count("bus_stop_o strobes", got_stop, exp_stop);
    check_count("rx_queue_wflush_o strobes", got_flush, exp_flush);
    check_count("bus_addr_valid_o strobes", got_addrs.size(), exp_addrs.size());
    check_count("rx_queue_wvalid_o strobes", got_bytes.size(), exp_bytes.size());
    check_count("rx_desc_queue_wvalid_o strobes", got_descs.size(), exp_descs.size());
    foreach (exp_addrs[i]) check_addr("bus_addr_o", got_addrs[i], exp_addrs[i]);
    foreach (exp_bytes[i]) check_byte("rx_queue_wdata_o", got_bytes[i], exp_bytes[i]);
    foreach (exp_descs[i]) check_desc("rx_desc_queue_wdata_o", got_descs[i], exp_descs[i]);
    exp_bytes.delete();
    got_bytes.delete();
    exp_addrs.delete();
    got_addrs.delete();
    exp_descs.delete();
    got_descs.delete();
    {exp_start, exp_rstart, exp_stop, exp_flush} = '0;
    {got_start, got_rstart, got_stop, got_flush} = '0;
  endtask

  task automatic run_case(int k);
    logic seen, matched, perr, tbit;
    logic [7:0] b;
    int good;
    controller_pkg::rx_desc_t d;
    if (!bus_open) begin
      i3c_en    <= c_i3c[k];
      sta_valid <= c_sv[k];
      sta_addr  <= c_sta[k];
      dyn_valid <= c_dv[k];
      dyn_addr  <= c_dyn[k];
      wait_clk(4);
      drive_start();
      exp_start++;
    end else begin
      drive_rstart();
      exp_rstart++;
    end
    drive_byte(c_addr[k]);
    ack_slot(seen);
    // Writes only; I3C prefers the dynamic address and accepts broadcast
    if (c_i3c[k]) begin
      matched = !c_addr[k][0] && ((c_dv[k] ? c_addr[k][7:1] == c_dyn[k] :
                (c_sv[k] && c_addr[k][7:1] == c_sta[k])) || c_addr[k][7:1] == 7'h7E);
    end else begin
      matched = !c_addr[k][0] && c_sv[k] && c_addr[k][7:1] == c_sta[k];
    end
    check_bit("ctrl_sda_o address ACK slot", seen, !matched);
    exp_addrs.push_back(c_addr[k]);
    perr = 1'b0;
    good = 0;
    for (int i = 0; i < c_cnt[k]; i++) begin
      if (c_data[k] == "random") b = 8'($urandom);
      else b = 8'(c_data[k].substr(3 * i, 3 * i + 1).atohex());
      drive_byte(b);
      if (c_i3c[k]) begin
        tbit = ~(^b);
        if (i == c_corrupt[k]) tbit = ~tbit;
        drive_bit(tbit);
        if (matched && !perr) begin
          if (i == c_corrupt[k]) begin
            perr = 1'b1;
            exp_flush++;
          end else begin
            exp_bytes.push_back(b);
            good++;
          end
        end
      end else begin
        ack_slot(seen);
        check_bit("ctrl_sda_o data ACK slot", seen, !matched);
        if (matched) begin
          exp_bytes.push_back(b);
          good++;
        end
      end
    end
    if (matched && (good > 0 || perr)) begin
      d = '{reserved: '0, parity_err: perr,
            mode: c_i3c[k] ? controller_pkg::MODE_I3C : controller_pkg::MODE_I2C,
            addr: c_addr[k][7:1], byte_count: 16'(good)};
      exp_descs.push_back(d);
    end
    if (c_rstart[k]) begin
      bus_open = 1'b1;
    end else begin
      drive_stop();
      exp_stop++;
      bus_open = 1'b0;
      wait_clk(6);
      verify_window();
    end
  endtask

  // Watchdog sized from the cases file
  initial begin
    wait (loaded);
    repeat (total_bits * 40 + 1000) @(posedge clk);
    $display("Timeout: the bus transfers did not finish in time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n_i   = 1'b0;
    scl_drv   = 1'b1;
    sda_drv   = 1'b1;
    i3c_en    = 1'b0;
    sta_valid = 1'b0;
    sta_addr  = '0;
    dyn_valid = 1'b0;
    dyn_addr  = '0;
    void'($urandom(32'h4800));
    load_cases();
    loaded = 1'b1;
    wait_clk(16);
    rst_n_i <= 1'b1;
    wait_clk(10);
    for (int k = 0; k < n_cases; k++) begin
      run_case(k);
    end
    if (bus_open) begin
      abort_run("cases file ends with the bus still open");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the standby target testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module controller_standby_tb --Mdir obj_dir -o sim_standby

./obj_dir/sim_standby | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: standby_macros.svh
// Widths and bus constants shared by the standby target, pulled in with `include
`ifndef STANDBY_MACROS_SVH
`define STANDBY_MACROS_SVH

`default_nettype none

// RX data queue word
`define STANDBY_DATA_W 8

// RX descriptor queue word
`define STANDBY_DESC_W 32

// I3C broadcast address, 7 bits
`define STANDBY_BCAST_ADDR 7'h7E

// Flops in each SCL/SDA input synchronizer
`define STANDBY_SYNC_STAGES 2

`default_nettype wire

`endif

// File: verilog.f
+incdir+.
controller_pkg.sv
controller_ifs.sv
bus_monitor.sv
controller_standby_i2c.sv
controller_standby_i3c.sv
controller_standby.sv
controller_standby_props.sv
controller_standby_tb.sv
